// File: common/dallanma_pkg.sv
package dallanma_pkg;

    // adres ve veri genisligi
    localparam int XLEN = 32;

    // dallanma buyrugu turu, 6 ve 7 kodlari gecersiz
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd2,
        BGE  = 3'd3,
        BLTU = 3'd4,
        BGEU = 3'd5
    } dal_tur_e;

    // coz/yurut asamasindan gelen dallanma istegi
    typedef struct packed {
        dal_tur_e          tur;
        logic [XLEN-1:0]   ps;             // dallanmanin program sayaci
        logic [XLEN-1:0]   br;             // dallanma anlik degeri
        logic [XLEN-1:0]   kaynak1;
        logic [XLEN-1:0]   kaynak2;
        logic              ongoru;         // getirde verilen karar, 1 ise atlar
        logic              sikistirilmis;  // 16 bitlik buyruk
    } dal_istek_t;

    // cozulen dallanmanin guncelleme kaydi
    typedef struct packed {
        logic              gecerli;
        logic              atladi;
        logic [XLEN-1:0]   ps;
        logic [XLEN-1:0]   hedef;          // dogru sonraki adres
    } dal_guncelle_t;

    // karsilastirici bayraklari, AMB'deki gibi
    typedef struct packed {
        logic esit_mi;
        logic buyuk_mu;                    // isaretli
        logic buyuk_mu_isaretsiz;
    } karsilastirma_t;

endpackage

// File: dallanma/dallanma_birimi.sv
`timescale 1ns/1ns

module dallanma_birimi
    import dallanma_pkg::*;
(
    input  logic           rst_i,
    input  logic           blok_aktif_i,
    input  logic           durdur_i,
    input  dal_istek_t     istek_i,
    input  karsilastirma_t bayrak_i,
    output dal_guncelle_t  guncelle_o,
    output logic           dallanma_hata_o
);

    logic            atla;
    logic            tur_gecerli;
    logic            gecerli;
    logic [XLEN-1:0] atlama_adresi;
    logic [XLEN-1:0] sonraki_adres;
    logic [XLEN-1:0] adim;
    logic            kucuk_isaretli;
    logic            kucuk_isaretsiz;

    // kucuk demek ne buyuk ne esit
    assign kucuk_isaretli  = !bayrak_i.buyuk_mu && !bayrak_i.esit_mi;
    assign kucuk_isaretsiz = !bayrak_i.buyuk_mu_isaretsiz && !bayrak_i.esit_mi;

    always_comb begin
        atla        = 1'b0;
        tur_gecerli = 1'b1;
        case (istek_i.tur)
            BEQ: begin
                atla = bayrak_i.esit_mi;
            end
            BNE: begin
                atla = !bayrak_i.esit_mi;
            end
            BLT: begin
                atla = kucuk_isaretli;
            end
            BGE: begin
                atla = bayrak_i.buyuk_mu || bayrak_i.esit_mi;
            end
            BLTU: begin
                atla = kucuk_isaretsiz;
            end
            BGEU: begin
                atla = bayrak_i.buyuk_mu_isaretsiz || bayrak_i.esit_mi;
            end
            default: begin
                tur_gecerli = 1'b0;  // 6 ve 7, guncelleme yok
            end
        endcase
    end

    // atlamazsa sikistirilmis buyrukta 2, tam buyrukta 4 ilerle
    assign adim          = istek_i.sikistirilmis ? XLEN'(2) : XLEN'(4);
    assign atlama_adresi = istek_i.ps + istek_i.br;  // tasma sarar
    assign sonraki_adres = istek_i.ps + adim;

    assign gecerli = rst_i && blok_aktif_i && !durdur_i && tur_gecerli;

    always_comb begin
        guncelle_o = '0;  // gecersizken tum alanlar sifir
        if (gecerli) begin
            guncelle_o.gecerli = 1'b1;
            guncelle_o.atladi  = atla;
            guncelle_o.ps      = istek_i.ps;
            guncelle_o.hedef   = atla ? atlama_adresi : sonraki_adres;
        end
    end

    // ongoru gercek karardan farkliysa hata, ps hedefe donmeli
    assign dallanma_hata_o = gecerli && (istek_i.ongoru != atla);

endmodule

// File: dallanma/dallanma_ongorucu.sv
`timescale 1ns/1ns

module dallanma_ongorucu
    import dallanma_pkg::*;
#(
    parameter int BHT_BIT = 6
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic [XLEN-1:0] tahmin_ps_i,
    output logic            tahmin_atla_o,
    input  dal_guncelle_t   guncelle_i
);

    localparam int          GIRDI_SAYISI  = 2 ** BHT_BIT;
    localparam logic [1:0]  ZAYIF_ATLAMAZ = 2'd1;
    localparam logic [1:0]  GUCLU_ATLAR   = 2'd3;
    localparam logic [1:0]  GUCLU_ATLAMAZ = 2'd0;

    logic [1:0]         sayac [GIRDI_SAYISI];
    logic [BHT_BIT-1:0] tahmin_indis;
    logic [BHT_BIT-1:0] guncelle_indis;
    logic [1:0]         guncel_sayac;
    logic [1:0]         yeni_sayac;

    // bit 1 kullanilmaz, sikistirilmis ciftler ayni girdiyi paylasir
    assign tahmin_indis   = tahmin_ps_i[BHT_BIT+1:2];
    assign guncelle_indis = guncelle_i.ps[BHT_BIT+1:2];

    assign guncel_sayac = sayac[guncelle_indis];

    // doyumlu sayac, 0 ile 3 arasinda kalir
    always_comb begin
        yeni_sayac = guncel_sayac;
        if (guncelle_i.atladi) begin
            if (guncel_sayac != GUCLU_ATLAR) begin
                yeni_sayac = guncel_sayac + 2'd1;
            end
        end else begin
            if (guncel_sayac != GUCLU_ATLAMAZ) begin
                yeni_sayac = guncel_sayac - 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < GIRDI_SAYISI; i++) begin
                sayac[i] <= ZAYIF_ATLAMAZ;
            end
        end else if (guncelle_i.gecerli) begin
            sayac[guncelle_indis] <= yeni_sayac;
        end
    end

    // getir tarafi icin kombinasyonel okuma, ust bit karar
    assign tahmin_atla_o = sayac[tahmin_indis][1];

endmodule

// File: dallanma_cozumu.f
common/dallanma_pkg.sv
logic/karsilastirici.sv
dallanma/dallanma_birimi.sv
dallanma/dallanma_ongorucu.sv
logic/dallanma_cozumu.sv
dv/dallanma_cozumu_assertions.sv
dv/dallanma_cozumu_tb.sv

// File: dv/dallanma_cozumu_assertions.sv
`timescale 1ns/1ns

module dallanma_cozumu_assertions
    import dallanma_pkg::*;
(
    input logic          clk_i,
    input logic          rst_i,
    input logic          durdur_i,
    input dal_guncelle_t guncelle_i,
    input logic          dallanma_hata_i
);

    // sifirlamada ve beklemede guncelleme olmaz
    sifirda_gecersiz: assert property (@(posedge clk_i) !rst_i |-> !guncelle_i.gecerli)
        else $error("update valid while reset is low");

    beklemede_gecersiz: assert property (@(posedge clk_i) durdur_i |-> !guncelle_i.gecerli)
        else $error("update valid while stalled");

    hata_gecerli: assert property (@(posedge clk_i) dallanma_hata_i |-> guncelle_i.gecerli)
        else $error("misprediction without a valid update");

    // gecersiz kayit sifir hedef tasir
    gecersiz_hedef: assert property (@(posedge clk_i)
        !guncelle_i.gecerli |-> (guncelle_i.hedef == '0))
        else $error("invalid update with nonzero target");

endmodule

bind dallanma_cozumu dallanma_cozumu_assertions i_dallanma_cozumu_assertions (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .durdur_i        (durdur_i),
    .guncelle_i      (guncelle_o),
    .dallanma_hata_i (dallanma_hata_o)
);

// File: dv/dallanma_cozumu_tb.sv
`timescale 1ns/1ns

module dallanma_cozumu_tb
    import dallanma_pkg::*;
;

    localparam int BHT_BIT          = 6;
    localparam int SIFIRLAMA_CEVRIM = 5;
    localparam int RASTGELE_SAYISI  = 300;
    localparam int HEDEF_SAYISI     = 9;
    localparam int ONGORU_SAYISI    = 4;
    localparam int BEKLEME_SAYISI   = 21;
    localparam int GECERSIZ_SAYISI  = 10;
    localparam int EGITIM_SAYISI    = 15;
    localparam int TOPLAM_ISTEK     = SIFIRLAMA_CEVRIM + RASTGELE_SAYISI + HEDEF_SAYISI
                                    + ONGORU_SAYISI + BEKLEME_SAYISI + GECERSIZ_SAYISI
                                    + EGITIM_SAYISI;

    logic            clk;
    logic            rst;
    logic            blok_aktif;
    logic            durdur;
    dal_istek_t      istek;
    logic [XLEN-1:0] tahmin_ps;
    logic            tahmin_atla;
    dal_guncelle_t   guncelle;
    logic            dallanma_hata;

    integer          tohum = 32'h5497_35ac;
    int              hata_sayisi = 0;
    int              kontrol_sayisi = 0;
    int              hata_bas = 0;
    int              kontrol_bas = 0;
    logic [1:0]      model_sayac [2**BHT_BIT];  // ongorucu tablosunun kopyasi

    dallanma_cozumu #(
        .BHT_BIT (BHT_BIT)
    ) i_dallanma_cozumu (
        .clk_i           (clk),
        .rst_i           (rst),
        .blok_aktif_i    (blok_aktif),
        .durdur_i        (durdur),
        .istek_i         (istek),
        .tahmin_ps_i     (tahmin_ps),
        .tahmin_atla_o   (tahmin_atla),
        .guncelle_o      (guncelle),
        .dallanma_hata_o (dallanma_hata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ISA kurallarina gore beklenen guncelleme ve hata
    function automatic dal_guncelle_t beklenen_guncelle(input dal_istek_t ist,
        input logic sifirsiz, input logic aktif, input logic dur, output logic hata);
        dal_guncelle_t g;
        logic          atla;
        logic          tur_dogru;
        atla      = 1'b0;
        tur_dogru = 1'b1;
        case (ist.tur)
            BEQ:     atla = (ist.kaynak1 == ist.kaynak2);
            BNE:     atla = (ist.kaynak1 != ist.kaynak2);
            BLT:     atla = ($signed(ist.kaynak1) < $signed(ist.kaynak2));
            BGE:     atla = ($signed(ist.kaynak1) >= $signed(ist.kaynak2));
            BLTU:    atla = (ist.kaynak1 < ist.kaynak2);
            BGEU:    atla = (ist.kaynak1 >= ist.kaynak2);
            default: tur_dogru = 1'b0;
        endcase
        g    = '0;
        hata = 1'b0;
        if (sifirsiz && aktif && !dur && tur_dogru) begin
            g.gecerli = 1'b1;
            g.atladi  = atla;
            g.ps      = ist.ps;
            g.hedef   = atla ? ist.ps + ist.br : ist.ps + (ist.sikistirilmis ? 32'd2 : 32'd4);
            hata      = (ist.ongoru != atla);
        end
        return g;
    endfunction

    function automatic dal_istek_t istek_yap(input logic [2:0] kod, input logic [XLEN-1:0] ps,
        input logic [XLEN-1:0] br, input logic [XLEN-1:0] k1, input logic [XLEN-1:0] k2,
        input logic ongoru, input logic sik);
        dal_istek_t ist;
        ist.tur           = dal_tur_e'(kod);
        ist.ps            = ps;
        ist.br            = br;
        ist.kaynak1       = k1;
        ist.kaynak2       = k2;
        ist.ongoru        = ongoru;
        ist.sikistirilmis = sik;
        return ist;
    endfunction

    function automatic dal_istek_t rastgele_istek(input logic [2:0] kod);
        dal_istek_t  ist;
        logic [31:0] rnd;
        logic [31:0] k1;
        logic [31:0] k2;
        rnd = $random(tohum);
        k1  = $random(tohum);
        k2  = $random(tohum);
        case (rnd[4:2])  // sinir degerleri de karistir
            3'd0, 3'd1: k2 = k1;
            3'd2: begin
                k1[31] = 1'b1;
                k2[31] = 1'b0;
            end
            3'd3: begin
                k1[31] = 1'b0;
                k2[31] = 1'b1;
            end
            3'd4: k1 = 32'hffff_ff00 | {24'd0, k1[7:0]};  // buyuk isaretsiz
            default: ;
        endcase
        ist = istek_yap(kod, $random(tohum) & 32'hffff_fffe, $random(tohum) & 32'hffff_fffe,
                        k1, k2, rnd[0], rnd[1]);
        return ist;
    endfunction

    task automatic istek_sur(input dal_istek_t ist, input logic aktif, input logic dur,
        input logic [XLEN-1:0] tps);
        @(posedge clk);
        istek      <= ist;
        blok_aktif <= aktif;
        durdur     <= dur;
        tahmin_ps  <= tps;
    endtask

    // BEQ ile istenen sonucu zorla
    task automatic egit(input logic [XLEN-1:0] ps, input logic atla, input logic ongoru,
        input logic aktif, input logic dur);
        istek_sur(istek_yap(3'd0, ps, 32'h100, 32'h1234_5678,
                            atla ? 32'h1234_5678 : 32'h8765_4321, ongoru, 1'b0),
                  aktif, dur, ps);
    endtask

    task automatic hata_yaz(input string ad, input logic [31:0] gelen, input logic [31:0] bek);
        hata_sayisi++;
        $display("error: %s got 0x%08h expected 0x%08h at %0t", ad, gelen, bek, $time);
    endtask

    task automatic test_bitir(input string ad);
        #3;  // son istegin kontrolu bitsin
        $display("test %s done: %0d checks, %0d errors", ad,
                 kontrol_sayisi - kontrol_bas, hata_sayisi - hata_bas);
        kontrol_bas = kontrol_sayisi;
        hata_bas    = hata_sayisi;
    endtask

    initial begin : karsilastir
        dal_guncelle_t      beklenen;
        dal_guncelle_t      onceki;
        logic               beklenen_hata;
        logic [BHT_BIT-1:0] indis;
        onceki = '0;
        for (int i = 0; i < 2**BHT_BIT; i++) begin
            model_sayac[i] = 2'd1;
        end
        forever begin
            @(posedge clk);
            #2;
            if (onceki.gecerli) begin  // tablo bu kenarda guncellendi
                indis = onceki.ps[BHT_BIT+1:2];
                if (onceki.atladi && model_sayac[indis] != 2'd3) begin
                    model_sayac[indis] = model_sayac[indis] + 2'd1;
                end else if (!onceki.atladi && model_sayac[indis] != 2'd0) begin
                    model_sayac[indis] = model_sayac[indis] - 2'd1;
                end
            end
            if (rst) begin
                kontrol_sayisi++;
                if (tahmin_atla !== model_sayac[tahmin_ps[BHT_BIT+1:2]][1]) begin
                    hata_yaz("tahmin_atla_o", 32'(tahmin_atla),
                             32'(model_sayac[tahmin_ps[BHT_BIT+1:2]][1]));
                end
            end
            beklenen = beklenen_guncelle(istek, rst, blok_aktif, durdur, beklenen_hata);
            kontrol_sayisi++;
            if (guncelle.gecerli !== beklenen.gecerli) begin
                hata_yaz("guncelle_o.gecerli", 32'(guncelle.gecerli), 32'(beklenen.gecerli));
            end
            if (guncelle.atladi !== beklenen.atladi) begin
                hata_yaz("guncelle_o.atladi", 32'(guncelle.atladi), 32'(beklenen.atladi));
            end
            if (guncelle.ps !== beklenen.ps) begin
                hata_yaz("guncelle_o.ps", guncelle.ps, beklenen.ps);
            end
            if (guncelle.hedef !== beklenen.hedef) begin
                hata_yaz("guncelle_o.hedef", guncelle.hedef, beklenen.hedef);
            end
            if (dallanma_hata !== beklenen_hata) begin
                hata_yaz("dallanma_hata_o", 32'(dallanma_hata), 32'(beklenen_hata));
            end
            onceki = beklenen;
        end
    end

    initial begin : bekci
        #((TOPLAM_ISTEK + 100) * 10);
        $display("timeout: the tests did not finish in the expected time");
        $display("Testbench failed");
        $finish;
    end

    initial begin : uyaran
        dal_istek_t  ist;
        logic [31:0] rnd;
        rst        = 1'b0;
        blok_aktif = 1'b0;
        durdur     = 1'b0;
        istek      = '0;
        tahmin_ps  = '0;
        for (int i = 0; i < SIFIRLAMA_CEVRIM - 1; i++) begin  // sifirlamada aktif istekler
            ist = rastgele_istek(3'd0);
            istek_sur(ist, 1'b1, 1'b0, ist.ps);
        end
        @(posedge clk);
        rst        <= 1'b1;
        blok_aktif <= 1'b0;
        test_bitir("reset");

        for (int i = 0; i < RASTGELE_SAYISI; i++) begin
            rnd = $random(tohum);
            ist = rastgele_istek(3'(rnd[15:0] % 16'd6));
            istek_sur(ist, 1'b1, 1'b0, ist.ps);
        end
        test_bitir("random types");

        istek_sur(istek_yap(3'd0, 32'h100, 32'hffff_fff0, 32'd7, 32'd7, 1'b1, 1'b0), 1, 0, 0);
        istek_sur(istek_yap(3'd1, 32'hffff_fff8, 32'h10, 32'd1, 32'd2, 1'b1, 1'b0), 1, 0, 0);
        istek_sur(istek_yap(3'd0, 32'h200, 32'h40, 32'd1, 32'd2, 1'b0, 1'b1), 1, 0, 0);
        istek_sur(istek_yap(3'd0, 32'h200, 32'h40, 32'd1, 32'd2, 1'b0, 1'b0), 1, 0, 0);
        istek_sur(istek_yap(3'd2, 32'h300, 32'h40, -32'sd5, -32'sd5, 1'b1, 1'b0), 1, 0, 0);
        istek_sur(istek_yap(3'd4, 32'h300, 32'h40, 32'hffff_0000, 32'hffff_0000, 1, 0), 1, 0, 0);
        istek_sur(istek_yap(3'd3, 32'h300, 32'h40, 32'h8000_0000, 32'h8000_0000, 0, 0), 1, 0, 0);
        istek_sur(istek_yap(3'd5, 32'h300, 32'h40, 32'd9, 32'd9, 1'b0, 1'b1), 1, 0, 0);
        istek_sur(istek_yap(3'd1, 32'hffff_fffe, 32'h40, 32'd3, 32'd3, 1'b0, 1'b1), 1, 0, 0);
        test_bitir("targets");

        egit(32'h400, 1'b0, 1'b0, 1'b1, 1'b0);  // ongoru ve sonuc ciftlerinin hepsi
        egit(32'h400, 1'b0, 1'b1, 1'b1, 1'b0);
        egit(32'h400, 1'b1, 1'b0, 1'b1, 1'b0);
        egit(32'h400, 1'b1, 1'b1, 1'b1, 1'b0);
        test_bitir("misprediction");

        // once sayaci atlar tarafina egit
        egit(32'h1040, 1'b0, 1'b0, 1'b1, 1'b0);
        egit(32'h1040, 1'b0, 1'b0, 1'b1, 1'b0);
        egit(32'h1040, 1'b1, 1'b0, 1'b1, 1'b0);
        egit(32'h1040, 1'b1, 1'b0, 1'b1, 1'b0);
        for (int i = 0; i < 8; i++) begin
            egit(32'h1040, 1'b0, 1'b1, 1'b1, 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            egit(32'h1040, 1'b0, 1'b1, 1'b0, 1'b0);
        end
        egit(32'h1040, 1'b0, 1'b1, 1'b0, 1'b0);
        test_bitir("stall and inactive");

        // gecersiz kaydin ps alani 0 oldugundan girdi 0 izlenir
        for (int i = 0; i < GECERSIZ_SAYISI; i++) begin
            ist     = rastgele_istek(3'd0);
            ist.tur = dal_tur_e'(3'd6 + 3'(i % 2));
            istek_sur(ist, 1'b1, 1'b0, '0);
        end
        test_bitir("invalid opcodes");

        for (int i = 0; i < 4; i++) begin
            egit(32'h2008, 1'b1, 1'b0, 1'b1, 1'b0);
        end
        for (int i = 0; i < 5; i++) begin
            egit(32'h2008, 1'b0, 1'b1, 1'b1, 1'b0);
        end
        egit(32'h200a, 1'b1, 1'b0, 1'b1, 1'b0);  // sikistirilmis cift ayni girdide
        egit(32'h2008, 1'b1, 1'b0, 1'b1, 1'b0);
        egit(32'h2008, 1'b0, 1'b0, 1'b0, 1'b0);
        egit(32'h200c, 1'b0, 1'b0, 1'b0, 1'b0);
        egit(32'h2004, 1'b0, 1'b0, 1'b0, 1'b0);
        egit(32'h200a, 1'b0, 1'b0, 1'b0, 1'b0);
        test_bitir("training");

        @(posedge clk);
        blok_aktif <= 1'b0;
        #3;
        $display("summary: %0d checks, %0d errors", kontrol_sayisi, hata_sayisi);
        if (hata_sayisi == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: logic/dallanma_cozumu.sv
`timescale 1ns/1ns

module dallanma_cozumu
    import dallanma_pkg::*;
#(
    parameter int BHT_BIT = 6
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            blok_aktif_i,
    input  logic            durdur_i,
    input  dal_istek_t      istek_i,
    input  logic [XLEN-1:0] tahmin_ps_i,
    output logic            tahmin_atla_o,
    output dal_guncelle_t   guncelle_o,
    output logic            dallanma_hata_o
);

    karsilastirma_t bayrak;
    dal_guncelle_t  guncelle;

    // AMB'nin karsilastirma bayraklari yerine
    karsilastirici i_karsilastirici (
        .kaynak1_i (istek_i.kaynak1),
        .kaynak2_i (istek_i.kaynak2),
        .bayrak_o  (bayrak)
    );

    dallanma_birimi i_dallanma_birimi (
        .rst_i           (rst_i),
        .blok_aktif_i    (blok_aktif_i),
        .durdur_i        (durdur_i),
        .istek_i         (istek_i),
        .bayrak_i        (bayrak),
        .guncelle_o      (guncelle),
        .dallanma_hata_o (dallanma_hata_o)
    );

    // ayni guncelleme hem disari hem tabloya gider
    dallanma_ongorucu #(
        .BHT_BIT (BHT_BIT)
    ) i_dallanma_ongorucu (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .tahmin_ps_i   (tahmin_ps_i),
        .tahmin_atla_o (tahmin_atla_o),
        .guncelle_i    (guncelle)
    );

    assign guncelle_o = guncelle;

endmodule

// File: logic/karsilastirici.sv
`timescale 1ns/1ns

module karsilastirici
    import dallanma_pkg::*;
(
    input  logic [XLEN-1:0] kaynak1_i,
    input  logic [XLEN-1:0] kaynak2_i,
    output karsilastirma_t  bayrak_o
);

    logic signed [XLEN-1:0] kaynak1_isaretli;
    logic signed [XLEN-1:0] kaynak2_isaretli;

    assign kaynak1_isaretli = kaynak1_i;
    assign kaynak2_isaretli = kaynak2_i;

    // kucuk-esit bayragi yok, birim bunu esit ve buyukten cikarir
    always_comb begin
        bayrak_o.esit_mi            = (kaynak1_i == kaynak2_i);
        bayrak_o.buyuk_mu           = (kaynak1_isaretli > kaynak2_isaretli);
        bayrak_o.buyuk_mu_isaretsiz = (kaynak1_i > kaynak2_i);
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module dallanma_cozumu_tb \
    -f dallanma_cozumu.f \
    -o dallanma_cozumu_sim

./obj_dir/dallanma_cozumu_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi
